// File: hdl/datapathPkg.sv
`default_nettype none

package datapathPkg;

        // **************************************************
        // Widths
        // **************************************************
        localparam int wordWidth = 32;
        localparam int registerCount = 16; // Four-bit register fields in IR.
        localparam int sourceWidth = 5;

        // **************************************************
        // ALU opcodes, same encoding as IR[31:27]
        // **************************************************
        typedef enum logic [4:0] {
                opAdd = 5'd3,
                opSub = 5'd4,
                opAnd = 5'd5,
                opOr = 5'd6,
                opShr = 5'd7,
                opShra = 5'd8,
                opShl = 5'd9,
                opRor = 5'd10,
                opRol = 5'd11,
                opNeg = 5'd17,
                opNot = 5'd18
        } aluOp;

        // **************************************************
        // Bus sources
        // **************************************************
        typedef enum logic [sourceWidth-1:0] {
                srcReg0, srcReg1, srcReg2, srcReg3,
                srcReg4, srcReg5, srcReg6, srcReg7,
                srcReg8, srcReg9, srcReg10, srcReg11,
                srcReg12, srcReg13, srcReg14, srcReg15,
                srcZLow, srcPc, srcMdr, srcInPort, srcConst, srcNone
        } busSource;

endpackage

`default_nettype wire

// File: hdl/registerFile.sv
`default_nettype none

module registerFile #(
        parameter int wordWidth = datapathPkg::wordWidth,
        parameter int registerCount = datapathPkg::registerCount
) (
        input wire logic Clock,
        input wire logic reset,
        input wire logic [wordWidth-1:0] busValue,
        input wire logic gra,
        input wire logic grb,
        input wire logic grc,
        input wire logic regIn,
        input wire logic regOut,
        input wire logic baOut,
        input wire logic pcIn,
        input wire logic irIn,
        input wire logic incrementPc,
        output logic [wordWidth-1:0] registerValue,
        output datapathPkg::busSource regRead,
        output logic [wordWidth-1:0] pcValue,
        output logic [wordWidth-1:0] irValue,
        output logic [wordWidth-1:0] constValue
);

        import datapathPkg::*;

        localparam int fieldWidth = $clog2(registerCount);

        logic [wordWidth-1:0] registerArray [registerCount];
        logic [registerCount-1:0] writeSelect;
        logic [fieldWidth-1:0] fieldSelect;

        // **************************************************
        // Select and encode
        // **************************************************
        assign fieldSelect = ({fieldWidth{gra}} & irValue[26 -: fieldWidth])
                | ({fieldWidth{grb}} & irValue[22 -: fieldWidth])
                | ({fieldWidth{grc}} & irValue[18 -: fieldWidth]);

        always_comb begin
                writeSelect = '0;
                writeSelect[fieldSelect] = regIn; // One-hot write enable.
        end

        // **************************************************
        // General registers
        // **************************************************
        for (genvar i = 0; i < registerCount; i++) begin : generalRegister
                logic [wordWidth-1:0] value;

                always_ff @(posedge Clock) begin
                        if (reset) begin
                                value <= '0;
                        end else if (writeSelect[i]) begin
                                value <= busValue;
                        end
                end

                assign registerArray[i] = value;
        end

        // R0 reads as zero for base addressing.
        assign registerValue = (baOut && fieldSelect == '0) ? '0 : registerArray[fieldSelect];

        assign regRead = (regOut || baOut) ? busSource'(sourceWidth'(fieldSelect)) : srcNone;

        // **************************************************
        // PC and IR
        // **************************************************
        always_ff @(posedge Clock) begin
                if (reset) begin
                        pcValue <= '0;
                end else if (pcIn) begin
                        pcValue <= busValue; // Bus load beats increment.
                end else if (incrementPc) begin
                        pcValue <= pcValue + 1'b1;
                end
        end

        always_ff @(posedge Clock) begin
                if (reset) begin
                        irValue <= '0;
                end else if (irIn) begin
                        irValue <= busValue;
                end
        end

        assign constValue = {{(wordWidth - 19){irValue[18]}}, irValue[18:0]}; // Sign extend.

        selectOneHot: assert property (@(posedge Clock) disable iff (reset)
                $onehot0({gra, grb, grc}))
                else $error("More than one register field selected.");

endmodule

`default_nettype wire

// File: hdl/memoryInterface.sv
`default_nettype none

module memoryInterface #(
        parameter int wordWidth = datapathPkg::wordWidth
) (
        input wire logic Clock,
        input wire logic reset,
        input wire logic [wordWidth-1:0] busValue,
        input wire logic [wordWidth-1:0] mdataIn,
        input wire logic read,
        input wire logic mdrIn,
        input wire logic marIn,
        output logic [wordWidth-1:0] mdrValue,
        output logic [wordWidth-1:0] marValue
);

        logic [wordWidth-1:0] mdrNext;

        // Memory data during a read, bus otherwise.
        assign mdrNext = read ? mdataIn : busValue;

        // **************************************************
        // MDR
        // **************************************************
        always_ff @(posedge Clock) begin
                if (reset) begin
                        mdrValue <= '0;
                end else if (mdrIn) begin
                        mdrValue <= mdrNext;
                end
        end

        // **************************************************
        // MAR
        // **************************************************
        always_ff @(posedge Clock) begin
                if (reset) begin
                        marValue <= '0;
                end else if (marIn) begin
                        marValue <= busValue; // Address for next read.
                end
        end

endmodule

`default_nettype wire

// File: hdl/arithmeticUnit.sv
`default_nettype none

module arithmeticUnit #(
        parameter int wordWidth = datapathPkg::wordWidth
) (
        input wire logic Clock,
        input wire logic reset,
        input wire logic [wordWidth-1:0] busValue,
        input wire logic yIn,
        input wire logic zIn,
        input wire datapathPkg::aluOp operation,
        output logic [wordWidth-1:0] zLowValue
);

        import datapathPkg::*;

        localparam int shiftWidth = $clog2(wordWidth);

        logic [wordWidth-1:0] yValue;
        logic [wordWidth-1:0] aluResult;
        logic [shiftWidth-1:0] shiftAmount;

        // **************************************************
        // Y operand
        // **************************************************
        always_ff @(posedge Clock) begin
                if (reset) begin
                        yValue <= '0;
                end else if (yIn) begin
                        yValue <= busValue;
                end
        end

        // **************************************************
        // ALU
        // **************************************************
        assign shiftAmount = busValue[shiftWidth-1:0];

        always_comb begin
                case (operation)
                        opAdd: aluResult = yValue + busValue;
                        opSub: aluResult = yValue - busValue;
                        opAnd: aluResult = yValue & busValue;
                        opOr: aluResult = yValue | busValue;
                        opShr: aluResult = yValue >> shiftAmount;
                        opShra: aluResult = $signed(yValue) >>> shiftAmount;
                        opShl: aluResult = yValue << shiftAmount;
                        opRor: begin
                                aluResult = (yValue >> shiftAmount)
                                        | (yValue << (wordWidth - shiftAmount));
                        end
                        opRol: begin
                                aluResult = (yValue << shiftAmount)
                                        | (yValue >> (wordWidth - shiftAmount));
                        end
                        opNeg: aluResult = '0 - busValue; // Bus only.
                        opNot: aluResult = ~busValue;
                        default: aluResult = '0;
                endcase
        end

        // **************************************************
        // Z result
        // **************************************************
        always_ff @(posedge Clock) begin
                if (reset) begin
                        zLowValue <= '0;
                end else if (zIn) begin
                        zLowValue <= aluResult;
                end
        end

        legalOperation: assert property (@(posedge Clock) disable iff (reset)
                zIn |-> operation inside {opAdd, opSub, opAnd, opOr, opShr, opShra,
                        opShl, opRor, opRol, opNeg, opNot})
                else $error("Illegal ALU opcode %0d under zIn.", operation);

endmodule

`default_nettype wire

// File: hdl/busEncoder.sv
`default_nettype none

module busEncoder #(
        parameter int wordWidth = datapathPkg::wordWidth
) (
        input wire datapathPkg::busSource regRead,
        input wire logic pcOut,
        input wire logic zLowOut,
        input wire logic mdrOut,
        input wire logic inPortOut,
        input wire logic cOut,
        input wire logic [wordWidth-1:0] registerValue,
        input wire logic [wordWidth-1:0] pcValue,
        input wire logic [wordWidth-1:0] zLowValue,
        input wire logic [wordWidth-1:0] mdrValue,
        input wire logic [wordWidth-1:0] inPort,
        input wire logic [wordWidth-1:0] constValue,
        output logic [wordWidth-1:0] busValue
);

        import datapathPkg::*;

        busSource source;

        // **************************************************
        // Encoder
        // **************************************************
        always_comb begin
                if (regRead != srcNone) begin
                        source = regRead; // Register number from IR field.
                end else if (pcOut) begin
                        source = srcPc;
                end else if (zLowOut) begin
                        source = srcZLow;
                end else if (mdrOut) begin
                        source = srcMdr;
                end else if (inPortOut) begin
                        source = srcInPort;
                end else if (cOut) begin
                        source = srcConst;
                end else begin
                        source = srcNone;
                end
        end

        // **************************************************
        // Bus multiplexer
        // **************************************************
        always_comb begin
                case (source)
                        srcZLow: busValue = zLowValue;
                        srcPc: busValue = pcValue;
                        srcMdr: busValue = mdrValue;
                        srcInPort: busValue = inPort;
                        srcConst: busValue = constValue;
                        srcNone: busValue = '0; // Idle bus.
                        default: busValue = registerValue;
                endcase
        end

        always_comb begin
                singleDriver: assert final ($onehot0({regRead != srcNone, pcOut, zLowOut,
                        mdrOut, inPortOut, cOut}))
                        else $error("More than one bus source active.");
        end

endmodule

`default_nettype wire

// File: hdl/busDatapath.sv
`default_nettype none

module busDatapath #(
        parameter int wordWidth = datapathPkg::wordWidth
) (
        input wire logic Clock,
        input wire logic reset,
        input wire logic [wordWidth-1:0] mdataIn,
        input wire logic [wordWidth-1:0] inPort,
        input wire logic pcOut,
        input wire logic zLowOut,
        input wire logic mdrOut,
        input wire logic inPortOut,
        input wire logic cOut,
        input wire logic regOut,
        input wire logic baOut,
        input wire logic gra,
        input wire logic grb,
        input wire logic grc,
        input wire logic regIn,
        input wire logic pcIn,
        input wire logic irIn,
        input wire logic marIn,
        input wire logic mdrIn,
        input wire logic yIn,
        input wire logic zIn,
        input wire logic incrementPc,
        input wire logic read,
        input wire datapathPkg::aluOp operation,
        output logic [wordWidth-1:0] busValue,
        output logic [wordWidth-1:0] marValue
);

        import datapathPkg::*;

        logic [wordWidth-1:0] registerValue;
        logic [wordWidth-1:0] pcValue;
        logic [wordWidth-1:0] constValue;
        logic [wordWidth-1:0] mdrValue;
        logic [wordWidth-1:0] zLowValue;
        busSource regRead;

        registerFile #(
                .wordWidth(wordWidth),
                .registerCount(registerCount)
        ) registers (
                .Clock(Clock), .reset(reset), .busValue(busValue),
                .gra(gra), .grb(grb), .grc(grc),
                .regIn(regIn), .regOut(regOut), .baOut(baOut),
                .pcIn(pcIn), .irIn(irIn), .incrementPc(incrementPc),
                .registerValue(registerValue), .regRead(regRead),
                .pcValue(pcValue), .irValue(), .constValue(constValue)
        );

        memoryInterface #(.wordWidth(wordWidth)) memory (
                .Clock(Clock), .reset(reset), .busValue(busValue),
                .mdataIn(mdataIn), .read(read), .mdrIn(mdrIn), .marIn(marIn),
                .mdrValue(mdrValue), .marValue(marValue)
        );

        arithmeticUnit #(.wordWidth(wordWidth)) arithmetic (
                .Clock(Clock), .reset(reset), .busValue(busValue),
                .yIn(yIn), .zIn(zIn), .operation(operation),
                .zLowValue(zLowValue)
        );

        busEncoder #(.wordWidth(wordWidth)) encoder (
                .regRead(regRead), .pcOut(pcOut), .zLowOut(zLowOut),
                .mdrOut(mdrOut), .inPortOut(inPortOut), .cOut(cOut),
                .registerValue(registerValue), .pcValue(pcValue),
                .zLowValue(zLowValue), .mdrValue(mdrValue),
                .inPort(inPort), .constValue(constValue),
                .busValue(busValue)
        );

endmodule

`default_nettype wire

// File: bench/datapathBench.sv
`default_nettype none

module datapathBench;

        import datapathPkg::*;

        localparam int clockPeriod = 4;
        localparam int timeoutCycles = 5000;
        localparam logic [31:0] seed = 32'h59a694a1;

        logic Clock;
        logic reset;
        logic [wordWidth-1:0] mdataIn;
        logic [wordWidth-1:0] inPort;
        logic pcOut, zLowOut, mdrOut, inPortOut, cOut, regOut, baOut;
        logic gra, grb, grc, regIn, pcIn, irIn, marIn, mdrIn, yIn, zIn;
        logic incrementPc, read;
        aluOp operation;
        logic [wordWidth-1:0] busValue;
        logic [wordWidth-1:0] marValue;

        logic [31:0] lfsrState;
        int errorCount = 0;
        int testErrors = 0;
        int testCount = 0;
        int failedTests = 0;
        logic finished = 1'b0;

        busDatapath #(.wordWidth(wordWidth)) UUT (.*);

        initial begin
                Clock = 1'b0;
                forever #(clockPeriod / 2) Clock = ~Clock;
        end

        // **************************************************
        // Stimulus helpers
        // **************************************************
        function automatic logic [31:0] lfsrNext(input logic [31:0] state);
                return state[0] ? ((state >> 1) ^ 32'hD0000001) : (state >> 1); // Galois form.
        endfunction

        task automatic randomBits(input int count, output logic [wordWidth-1:0] value);
                value = '0;
                for (int i = 0; i < count; i++) begin
                        lfsrState = lfsrNext(lfsrState);
                        value = {value[wordWidth-2:0], lfsrState[0]};
                end
        endtask

        task automatic clearStrobes();
                {pcOut, zLowOut, mdrOut, inPortOut, cOut, regOut, baOut} = '0;
                {gra, grb, grc, regIn, pcIn, irIn, marIn, mdrIn, yIn, zIn} = '0;
                {incrementPc, read} = '0;
                operation = opAdd;
        endtask

        // One T-step. Strobes set before the call act at this edge.
        task automatic tick();
                @(posedge Clock);
                #1;
                clearStrobes();
        endtask

        function automatic logic [wordWidth-1:0] makeIr(input aluOp op, input int ra,
                        input int rb, input int rc);
                return {op, ra[3:0], rb[3:0], rc[3:0], 15'b0};
        endfunction

        task automatic selectField(input int field);
                gra = (field == 0);
                grb = (field == 1);
                grc = (field == 2);
        endtask

        task automatic loadMdr(input logic [wordWidth-1:0] value);
                mdataIn = value;
                read = 1'b1;
                mdrIn = 1'b1;
                tick();
        endtask

        task automatic loadIr(input logic [wordWidth-1:0] word);
                loadMdr(word);
                mdrOut = 1'b1;
                irIn = 1'b1;
                tick();
        endtask

        task automatic writeRegister(input int field, input logic [wordWidth-1:0] value);
                loadMdr(value);
                mdrOut = 1'b1;
                regIn = 1'b1;
                selectField(field);
                tick();
        endtask

        // **************************************************
        // Reference model and compares
        // **************************************************
        function automatic logic [wordWidth-1:0] aluModel(input aluOp op,
                        input logic [wordWidth-1:0] y, input logic [wordWidth-1:0] b);
                logic [2*wordWidth-1:0] doubled;
                logic [4:0] amount;
                amount = b[4:0];
                case (op)
                        opAdd: return y + b;
                        opSub: return y + ~b + 1;
                        opAnd: return y & b;
                        opOr: return y | b;
                        opShr: return y >> amount;
                        opShra: begin
                                doubled = {{wordWidth{y[wordWidth-1]}}, y} >> amount;
                                return doubled[wordWidth-1:0];
                        end
                        opShl: return y << amount;
                        opRor: begin
                                doubled = {y, y} >> amount;
                                return doubled[wordWidth-1:0];
                        end
                        opRol: begin
                                doubled = {y, y} << amount;
                                return doubled[2*wordWidth-1:wordWidth];
                        end
                        opNeg: return ~b + 1;
                        opNot: return ~b;
                        default: return '0;
                endcase
        endfunction

        task automatic checkWord(input string name, input logic [wordWidth-1:0] expected,
                        input logic [wordWidth-1:0] actual);
                if (actual !== expected) begin
                        $display("MISMATCH %s expected %h actual %h", name, expected, actual);
                        errorCount++;
                        testErrors++;
                end
        endtask

        task automatic checkOp(input string name, input aluOp op,
                        input logic [wordWidth-1:0] expected, input logic [wordWidth-1:0] actual);
                if (actual !== expected) begin
                        $display("MISMATCH %s %s expected %h actual %h", name, op.name(),
                                expected, actual);
                        errorCount++;
                        testErrors++;
                end
        endtask

        // Bus is sampled mid-cycle, after the strobes settle.
        task automatic expectBus(input string name, input logic [wordWidth-1:0] expected);
                #1;
                checkWord(name, expected, busValue);
                tick();
        endtask

        task automatic finishTest(input string name);
                testCount++;
                if (testErrors == 0) begin
                        $display("PASS %s", name);
                end else begin
                        failedTests++;
                        $display("FAIL %s with %0d errors", name, testErrors);
                end
                testErrors = 0;
        endtask

        // **************************************************
        // Directed tests
        // **************************************************
        task automatic resetTest();
                expectBus("reset", '0); // Idle bus.
                pcOut = 1'b1;
                expectBus("reset", '0);
                mdrOut = 1'b1;
                expectBus("reset", '0);
                zLowOut = 1'b1;
                expectBus("reset", '0);
                checkWord("reset", '0, marValue);
                finishTest("reset");
        endtask

        task automatic registerTest();
                logic [wordWidth-1:0] saved [registerCount];
                for (int i = 0; i < registerCount; i++) begin
                        loadIr(makeIr(opAdd, i, 0, 0));
                        randomBits(wordWidth, saved[i]);
                        writeRegister(0, saved[i]);
                        selectField(0);
                        regOut = 1'b1;
                        expectBus($sformatf("registers R%0d", i), saved[i]);
                end
                for (int i = 0; i < registerCount; i++) begin
                        loadIr(makeIr(opAdd, i, 0, 0));
                        selectField(0);
                        regOut = 1'b1;
                        expectBus($sformatf("registers reread R%0d", i), saved[i]);
                end
                finishTest("registers");
        endtask

        task automatic aluTest();
                aluOp op;
                logic [wordWidth-1:0] yOperand;
                logic [wordWidth-1:0] bOperand;
                op = op.first();
                for (int n = 0; n < op.num(); n++) begin
                        loadIr(makeIr(op, 3, 1, 2));
                        randomBits(wordWidth, yOperand);
                        randomBits(wordWidth, bOperand);
                        writeRegister(1, yOperand);
                        writeRegister(2, bOperand);
                        selectField(1);
                        regOut = 1'b1;
                        yIn = 1'b1;
                        tick();
                        selectField(2);
                        regOut = 1'b1;
                        zIn = 1'b1;
                        operation = op;
                        tick();
                        zLowOut = 1'b1;
                        #1;
                        checkOp("alu", op, aluModel(op, yOperand, bOperand), busValue);
                        tick();
                        op = op.next();
                end
                finishTest("alu");
        endtask

        task automatic fetchTest();
                logic [wordWidth-1:0] pcStart;
                logic [wordWidth-1:0] rbValue;
                logic [wordWidth-1:0] rcValue;
                randomBits(16, pcStart);
                randomBits(wordWidth, rbValue);
                randomBits(wordWidth, rcValue);
                loadIr(makeIr(opAdd, 5, 6, 8)); // Fields differ from the fetched word.
                writeRegister(0, rbValue);
                writeRegister(1, rcValue);
                loadMdr(pcStart);
                mdrOut = 1'b1;
                pcIn = 1'b1;
                tick();
                pcOut = 1'b1; // T0.
                marIn = 1'b1;
                incrementPc = 1'b1;
                tick();
                checkWord("fetch", pcStart, marValue);
                loadMdr(makeIr(opAnd, 7, 5, 6)); // T1, memory answers.
                mdrOut = 1'b1; // T2.
                irIn = 1'b1;
                tick();
                selectField(1);
                regOut = 1'b1;
                yIn = 1'b1;
                tick();
                selectField(2);
                regOut = 1'b1;
                zIn = 1'b1;
                operation = opAnd;
                tick();
                zLowOut = 1'b1;
                selectField(0);
                regIn = 1'b1;
                tick();
                pcOut = 1'b1;
                expectBus("fetch", pcStart + 1);
                selectField(0);
                regOut = 1'b1;
                expectBus("fetch", rbValue & rcValue);
                finishTest("fetch");
        endtask

        task automatic specialSourceTest();
                logic [wordWidth-1:0] value;
                logic [wordWidth-1:0] word;
                logic [wordWidth-1:0] constExpected;
                randomBits(wordWidth, value);
                value[0] = 1'b1; // Keep R0 nonzero.
                loadIr(makeIr(opAdd, 0, 0, 0));
                writeRegister(0, value);
                selectField(0);
                baOut = 1'b1;
                expectBus("special", '0);
                selectField(0);
                regOut = 1'b1;
                expectBus("special", value);
                for (int sign = 0; sign < 2; sign++) begin
                        randomBits(wordWidth, word);
                        word[18] = sign[0];
                        loadIr(word);
                        constExpected = word & ((1 << 19) - 1); // Low 19 bits.
                        if (word[18]) begin
                                constExpected = constExpected - (1 << 19); // Negative field.
                        end
                        cOut = 1'b1;
                        expectBus("special", constExpected);
                end
                randomBits(wordWidth, inPort);
                inPortOut = 1'b1;
                expectBus("special", inPort);
                randomBits(wordWidth, value);
                loadMdr(value);
                mdrOut = 1'b1;
                pcIn = 1'b1;
                incrementPc = 1'b1;
                tick();
                pcOut = 1'b1;
                expectBus("special", value);
                finishTest("special");
        endtask

        // **************************************************
        // Sequence and watchdog
        // **************************************************
        initial begin
                lfsrState = seed;
                reset = 1'b1;
                mdataIn = '0;
                inPort = '0;
                clearStrobes();
                repeat (5) @(posedge Clock);
                #1;
                reset = 1'b0;
                resetTest();
                registerTest();
                aluTest();
                fetchTest();
                specialSourceTest();
                finished = 1'b1;
                $display("Tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
                if (errorCount == 0) begin
                        $display("Test OK");
                end else begin
                        $display("Test FAILED");
                end
                $finish;
        end

        initial begin
                for (int cycle = 0; cycle < timeoutCycles && !finished; cycle++) begin
                        @(posedge Clock);
                end
                if (!finished) begin
                        $display("Timeout: the tests did not finish in %0d cycles", timeoutCycles);
                        $display("Test FAILED");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// File: list.f
hdl/datapathPkg.sv
hdl/registerFile.sv
hdl/memoryInterface.sv
hdl/arithmeticUnit.sv
hdl/busEncoder.sv
hdl/busDatapath.sv
bench/datapathBench.sv

// File: Makefile
SOURCES := list.f $(wildcard hdl/*.sv bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/VdatapathBench: $(SOURCES)
	verilator --binary --timing --assert --top-module datapathBench -f list.f

sim.log: obj_dir/VdatapathBench
	./obj_dir/VdatapathBench | tee sim.log

run: obj_dir/VdatapathBench
	./obj_dir/VdatapathBench | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
